// ==== src/mem_rs_pkg.sv ====
`default_nettype none

package mem_rs_pkg;

    ////////////////////////////////////////////////////////////
    // Station, CDB and register file sizes
    ////////////////////////////////////////////////////////////

    localparam int MEMRS_DEPTH = 8;
    localparam int MEMRS_IDX   = 3;
    localparam int CDB_WIDTH   = 2;
    localparam int PRF_DEPTH   = 64;
    localparam int PHY_W       = 6;
    localparam int ROB_W       = 5;
    localparam int XLEN        = 32;
    localparam int IMM_W       = 12;
    localparam int OP_W        = 3;

    // Byte lanes of one data word
    localparam int LANES  = XLEN / 8;
    localparam int LANE_W = $clog2(LANES);

    ////////////////////////////////////////////////////////////
    // Memory opcodes
    ////////////////////////////////////////////////////////////

    // Stores live in the upper half of the code space
    localparam logic [OP_W-1:0] OP_LB  = 3'b000;
    localparam logic [OP_W-1:0] OP_LH  = 3'b001;
    localparam logic [OP_W-1:0] OP_LW  = 3'b010;
    localparam logic [OP_W-1:0] OP_LBU = 3'b011;
    localparam logic [OP_W-1:0] OP_SB  = 3'b100;
    localparam logic [OP_W-1:0] OP_SH  = 3'b101;
    localparam logic [OP_W-1:0] OP_SW  = 3'b110;
    // Last free code, the one load with the top bit set
    localparam logic [OP_W-1:0] OP_LHU = 3'b111;

    // Access sizes and their unshifted byte masks
    localparam logic [1:0] SZ_BYTE = 2'd0;
    localparam logic [1:0] SZ_HALF = 2'd1;
    localparam logic [1:0] SZ_WORD = 2'd2;

    localparam logic [LANES-1:0] BMASK_BYTE = 4'b0001;
    localparam logic [LANES-1:0] BMASK_HALF = 4'b0011;
    localparam logic [LANES-1:0] BMASK_WORD = 4'b1111;

    // Top opcode bit marks a store
    function automatic logic is_store(input logic [OP_W-1:0] op);
        return op[OP_W-1] && (op != OP_LHU);
    endfunction

    function automatic logic [1:0] access_size(input logic [OP_W-1:0] op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return SZ_BYTE;
            OP_LH, OP_LHU, OP_SH: return SZ_HALF;
            OP_LW, OP_SW:         return SZ_WORD;
            default:              return SZ_WORD;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/rs_slot.sv ====
`default_nettype none
`timescale 1ns/1ps

module rs_slot (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              push_en,
    input  logic [mem_rs_pkg::ROB_W-1:0]      ds_rob_id,
    input  logic [mem_rs_pkg::OP_W-1:0]       ds_op,
    input  logic [mem_rs_pkg::PHY_W-1:0]      ds_rs1_phy,
    input  logic                              ds_rs1_ready,
    input  logic [mem_rs_pkg::PHY_W-1:0]      ds_rs2_phy,
    input  logic                              ds_rs2_ready,
    input  logic [mem_rs_pkg::IMM_W-1:0]      ds_imm,
    input  logic                              grant,
    input  logic [mem_rs_pkg::CDB_WIDTH-1:0]  cdb_valid,
    input  logic [mem_rs_pkg::PHY_W-1:0]      cdb_tag [mem_rs_pkg::CDB_WIDTH],
    output logic                              valid,
    output logic                              request,
    output logic [mem_rs_pkg::ROB_W-1:0]      rob_id,
    output logic [mem_rs_pkg::OP_W-1:0]       op,
    output logic [mem_rs_pkg::PHY_W-1:0]      rs1_phy,
    output logic [mem_rs_pkg::PHY_W-1:0]      rs2_phy,
    output logic [mem_rs_pkg::IMM_W-1:0]      imm
);

    logic                         rs1_rdy;
    logic                         rs2_rdy;
    logic [mem_rs_pkg::PHY_W-1:0] tag1_cmp;
    logic [mem_rs_pkg::PHY_W-1:0] tag2_cmp;
    logic                         hit1;
    logic                         hit2;

    // On a push the incoming tags are the ones to watch
    assign tag1_cmp = push_en ? ds_rs1_phy : rs1_phy;
    assign tag2_cmp = push_en ? ds_rs2_phy : rs2_phy;

    // CDB tag match
    always_comb begin
        hit1 = 1'b0;
        hit2 = 1'b0;
        for (int i = 0; i < mem_rs_pkg::CDB_WIDTH; i++) begin
            if (cdb_valid[i] && (cdb_tag[i] == tag1_cmp)) begin
                hit1 = 1'b1;
            end
            if (cdb_valid[i] && (cdb_tag[i] == tag2_cmp)) begin
                hit2 = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid   <= 1'b0;
            rs1_rdy <= 1'b0;
            rs2_rdy <= 1'b0;
        end else if (push_en) begin
            valid   <= 1'b1;
            rs1_rdy <= ds_rs1_ready | hit1;
            rs2_rdy <= ds_rs2_ready | hit2;
        end else if (valid) begin
            // Freed at the edge that ends the grant cycle
            if (grant) begin
                valid <= 1'b0;
            end
            rs1_rdy <= rs1_rdy | hit1;
            rs2_rdy <= rs2_rdy | hit2;
        end
    end

    // Micro-op payload
    always_ff @(posedge clk) begin
        if (push_en) begin
            rob_id  <= ds_rob_id;
            op      <= ds_op;
            rs1_phy <= ds_rs1_phy;
            rs2_phy <= ds_rs2_phy;
            imm     <= ds_imm;
        end
    end

    // Loads only need the base register
    assign request = valid && rs1_rdy && (rs2_rdy || !mem_rs_pkg::is_store(op));

    // The station push logic must only pick free slots
    a_push_free: assert property (@(posedge clk) disable iff (!rst_n) push_en |-> !valid);

endmodule

`default_nettype wire

// ==== src/mem_rs.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_rs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              ds_valid,
    output logic                              ds_ready,
    input  logic [mem_rs_pkg::ROB_W-1:0]      ds_rob_id,
    input  logic [mem_rs_pkg::OP_W-1:0]       ds_op,
    input  logic [mem_rs_pkg::PHY_W-1:0]      ds_rs1_phy,
    input  logic                              ds_rs1_ready,
    input  logic [mem_rs_pkg::PHY_W-1:0]      ds_rs2_phy,
    input  logic                              ds_rs2_ready,
    input  logic [mem_rs_pkg::IMM_W-1:0]      ds_imm,
    input  logic [mem_rs_pkg::CDB_WIDTH-1:0]  cdb_valid,
    input  logic [mem_rs_pkg::PHY_W-1:0]      cdb_tag [mem_rs_pkg::CDB_WIDTH],
    output logic [mem_rs_pkg::PHY_W-1:0]      rd_tag1,
    output logic [mem_rs_pkg::PHY_W-1:0]      rd_tag2,
    output logic                              issue_valid,
    output logic [mem_rs_pkg::ROB_W-1:0]      issue_rob_id,
    output logic [mem_rs_pkg::OP_W-1:0]       issue_op,
    output logic [mem_rs_pkg::IMM_W-1:0]      issue_imm
);

    ////////////////////////////////////////////////////////////
    // Slot array
    ////////////////////////////////////////////////////////////

    logic [mem_rs_pkg::MEMRS_DEPTH-1:0] slot_valid;
    logic [mem_rs_pkg::MEMRS_DEPTH-1:0] slot_request;
    logic [mem_rs_pkg::MEMRS_DEPTH-1:0] slot_grant;
    logic [mem_rs_pkg::MEMRS_DEPTH-1:0] slot_push;
    logic [mem_rs_pkg::ROB_W-1:0]       slot_rob_id  [mem_rs_pkg::MEMRS_DEPTH];
    logic [mem_rs_pkg::OP_W-1:0]        slot_op      [mem_rs_pkg::MEMRS_DEPTH];
    logic [mem_rs_pkg::PHY_W-1:0]       slot_rs1_phy [mem_rs_pkg::MEMRS_DEPTH];
    logic [mem_rs_pkg::PHY_W-1:0]       slot_rs2_phy [mem_rs_pkg::MEMRS_DEPTH];
    logic [mem_rs_pkg::IMM_W-1:0]       slot_imm     [mem_rs_pkg::MEMRS_DEPTH];
    logic [mem_rs_pkg::MEMRS_IDX-1:0]   push_idx;

    for (genvar g = 0; g < mem_rs_pkg::MEMRS_DEPTH; g++) begin : g_slot
        rs_slot slot_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .push_en      (slot_push[g]),
            .ds_rob_id    (ds_rob_id),
            .ds_op        (ds_op),
            .ds_rs1_phy   (ds_rs1_phy),
            .ds_rs1_ready (ds_rs1_ready),
            .ds_rs2_phy   (ds_rs2_phy),
            .ds_rs2_ready (ds_rs2_ready),
            .ds_imm       (ds_imm),
            .grant        (slot_grant[g]),
            .cdb_valid    (cdb_valid),
            .cdb_tag      (cdb_tag),
            .valid        (slot_valid[g]),
            .request      (slot_request[g]),
            .rob_id       (slot_rob_id[g]),
            .op           (slot_op[g]),
            .rs1_phy      (slot_rs1_phy[g]),
            .rs2_phy      (slot_rs2_phy[g]),
            .imm          (slot_imm[g])
        );
    end

    // Room for one more micro-op
    assign ds_ready = |(~slot_valid);

    // Lowest free slot, scanned from the top so the low index wins
    always_comb begin
        push_idx = '0;
        for (int i = mem_rs_pkg::MEMRS_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                push_idx = i[mem_rs_pkg::MEMRS_IDX-1:0];
            end
        end
    end

    always_comb begin
        slot_push = '0;
        if (ds_valid && ds_ready) begin
            slot_push[push_idx] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Issue select
    ////////////////////////////////////////////////////////////

    // Lowest requesting index gets the grant
    always_comb begin
        slot_grant = '0;
        for (int i = mem_rs_pkg::MEMRS_DEPTH - 1; i >= 0; i--) begin
            if (slot_request[i]) begin
                slot_grant = '0;
                slot_grant[i] = 1'b1;
            end
        end
    end

    // AND-OR mux on the one-hot grant
    always_comb begin
        issue_rob_id = '0;
        issue_op     = '0;
        issue_imm    = '0;
        rd_tag1      = '0;
        rd_tag2      = '0;
        for (int i = 0; i < mem_rs_pkg::MEMRS_DEPTH; i++) begin
            issue_rob_id |= slot_rob_id[i] & {mem_rs_pkg::ROB_W{slot_grant[i]}};
            issue_op     |= slot_op[i] & {mem_rs_pkg::OP_W{slot_grant[i]}};
            issue_imm    |= slot_imm[i] & {mem_rs_pkg::IMM_W{slot_grant[i]}};
            rd_tag1      |= slot_rs1_phy[i] & {mem_rs_pkg::PHY_W{slot_grant[i]}};
            rd_tag2      |= slot_rs2_phy[i] & {mem_rs_pkg::PHY_W{slot_grant[i]}};
        end
    end

    assign issue_valid = |slot_request;

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(slot_grant));

    a_grant_requested: assert property (@(posedge clk) disable iff (!rst_n)
        (slot_grant & ~slot_request) == '0);

endmodule

`default_nettype wire

// ==== src/phys_reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [mem_rs_pkg::CDB_WIDTH-1:0]  cdb_valid,
    input  logic [mem_rs_pkg::PHY_W-1:0]      cdb_tag   [mem_rs_pkg::CDB_WIDTH],
    input  logic [mem_rs_pkg::XLEN-1:0]       cdb_value [mem_rs_pkg::CDB_WIDTH],
    input  logic [mem_rs_pkg::PHY_W-1:0]      rd_tag1,
    input  logic [mem_rs_pkg::PHY_W-1:0]      rd_tag2,
    output logic [mem_rs_pkg::XLEN-1:0]       rd_value1,
    output logic [mem_rs_pkg::XLEN-1:0]       rd_value2
);

    ////////////////////////////////////////////////////////////
    // Register storage
    ////////////////////////////////////////////////////////////

    logic [mem_rs_pkg::XLEN-1:0] regs [mem_rs_pkg::PRF_DEPTH];

    // One write per CDB lane
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else begin
            for (int l = 0; l < mem_rs_pkg::CDB_WIDTH; l++) begin
                if (cdb_valid[l]) begin
                    regs[cdb_tag[l]] <= cdb_value[l];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Same-cycle read for the granted entry
    // A value broadcast this cycle shows up one edge later
    assign rd_value1 = regs[rd_tag1];
    assign rd_value2 = regs[rd_tag2];

endmodule

`default_nettype wire

// ==== src/agu_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module agu_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              issue_valid,
    input  logic [mem_rs_pkg::ROB_W-1:0]      issue_rob_id,
    input  logic [mem_rs_pkg::OP_W-1:0]       issue_op,
    input  logic [mem_rs_pkg::IMM_W-1:0]      issue_imm,
    input  logic [mem_rs_pkg::XLEN-1:0]       rs1_value,
    input  logic [mem_rs_pkg::XLEN-1:0]       rs2_value,
    output logic                              lsq_valid,
    output logic [mem_rs_pkg::ROB_W-1:0]      lsq_rob_id,
    output logic                              lsq_is_store,
    output logic [mem_rs_pkg::XLEN-1:0]       lsq_addr,
    output logic [mem_rs_pkg::LANES-1:0]      lsq_mask,
    output logic [mem_rs_pkg::XLEN-1:0]       lsq_wdata,
    output logic                              lsq_misaligned
);

    logic [mem_rs_pkg::XLEN-1:0]   imm_ext;
    logic [mem_rs_pkg::XLEN-1:0]   addr_next;
    logic [mem_rs_pkg::LANE_W-1:0] offset;
    logic [1:0]                    size;
    logic                          store_next;
    logic [mem_rs_pkg::LANES-1:0]  base_mask;
    logic [mem_rs_pkg::LANES-1:0]  mask_next;
    logic [mem_rs_pkg::XLEN-1:0]   wdata_next;
    logic                          mis_next;

    assign imm_ext = {{(mem_rs_pkg::XLEN - mem_rs_pkg::IMM_W){issue_imm[mem_rs_pkg::IMM_W-1]}},
                      issue_imm};
    assign addr_next  = rs1_value + imm_ext;
    assign offset     = addr_next[mem_rs_pkg::LANE_W-1:0];
    assign size       = mem_rs_pkg::access_size(issue_op);
    assign store_next = mem_rs_pkg::is_store(issue_op);

    always_comb begin
        case (size)
            mem_rs_pkg::SZ_BYTE: base_mask = mem_rs_pkg::BMASK_BYTE;
            mem_rs_pkg::SZ_HALF: base_mask = mem_rs_pkg::BMASK_HALF;
            default:             base_mask = mem_rs_pkg::BMASK_WORD;
        endcase
    end

    // Lanes past the top of the word drop off
    assign mask_next  = base_mask << offset;
    assign wdata_next = store_next ? (rs2_value << {offset, 3'b000}) : '0;

    always_comb begin
        case (size)
            mem_rs_pkg::SZ_HALF: mis_next = offset[0];
            mem_rs_pkg::SZ_WORD: mis_next = (offset != '0);
            default:             mis_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lsq_valid <= 1'b0;
        end else begin
            lsq_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            lsq_rob_id     <= issue_rob_id;
            lsq_is_store   <= store_next;
            lsq_addr       <= addr_next;
            lsq_mask       <= mask_next;
            lsq_wdata      <= wdata_next;
            lsq_misaligned <= mis_next;
        end
    end

    a_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        lsq_valid |-> (lsq_mask != '0));

endmodule

`default_nettype wire

// ==== src/mem_issue_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_issue_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              ds_valid,
    output logic                              ds_ready,
    input  logic [mem_rs_pkg::ROB_W-1:0]      ds_rob_id,
    input  logic [mem_rs_pkg::OP_W-1:0]       ds_op,
    input  logic [mem_rs_pkg::PHY_W-1:0]      ds_rs1_phy,
    input  logic                              ds_rs1_ready,
    input  logic [mem_rs_pkg::PHY_W-1:0]      ds_rs2_phy,
    input  logic                              ds_rs2_ready,
    input  logic [mem_rs_pkg::IMM_W-1:0]      ds_imm,
    input  logic [mem_rs_pkg::CDB_WIDTH-1:0]  cdb_valid,
    input  logic [mem_rs_pkg::PHY_W-1:0]      cdb_tag   [mem_rs_pkg::CDB_WIDTH],
    input  logic [mem_rs_pkg::XLEN-1:0]       cdb_value [mem_rs_pkg::CDB_WIDTH],
    output logic                              lsq_valid,
    output logic [mem_rs_pkg::ROB_W-1:0]      lsq_rob_id,
    output logic                              lsq_is_store,
    output logic [mem_rs_pkg::XLEN-1:0]       lsq_addr,
    output logic [mem_rs_pkg::LANES-1:0]      lsq_mask,
    output logic [mem_rs_pkg::XLEN-1:0]       lsq_wdata,
    output logic                              lsq_misaligned
);

    logic [mem_rs_pkg::PHY_W-1:0] rd_tag1;
    logic [mem_rs_pkg::PHY_W-1:0] rd_tag2;
    logic [mem_rs_pkg::XLEN-1:0]  rd_value1;
    logic [mem_rs_pkg::XLEN-1:0]  rd_value2;
    logic                         issue_valid;
    logic [mem_rs_pkg::ROB_W-1:0] issue_rob_id;
    logic [mem_rs_pkg::OP_W-1:0]  issue_op;
    logic [mem_rs_pkg::IMM_W-1:0] issue_imm;

    mem_rs rs_i (
        .clk (clk), .rst_n (rst_n),
        .ds_valid (ds_valid), .ds_ready (ds_ready), .ds_rob_id (ds_rob_id), .ds_op (ds_op),
        .ds_rs1_phy (ds_rs1_phy), .ds_rs1_ready (ds_rs1_ready),
        .ds_rs2_phy (ds_rs2_phy), .ds_rs2_ready (ds_rs2_ready), .ds_imm (ds_imm),
        .cdb_valid (cdb_valid), .cdb_tag (cdb_tag),
        .rd_tag1 (rd_tag1), .rd_tag2 (rd_tag2),
        .issue_valid (issue_valid), .issue_rob_id (issue_rob_id),
        .issue_op (issue_op), .issue_imm (issue_imm)
    );

    // Operands for the granted entry, read in its grant cycle
    phys_reg_file prf_i (
        .clk (clk), .rst_n (rst_n),
        .cdb_valid (cdb_valid), .cdb_tag (cdb_tag), .cdb_value (cdb_value),
        .rd_tag1 (rd_tag1), .rd_tag2 (rd_tag2),
        .rd_value1 (rd_value1), .rd_value2 (rd_value2)
    );

    agu_stage agu_i (
        .clk (clk), .rst_n (rst_n),
        .issue_valid (issue_valid), .issue_rob_id (issue_rob_id),
        .issue_op (issue_op), .issue_imm (issue_imm),
        .rs1_value (rd_value1), .rs2_value (rd_value2),
        .lsq_valid (lsq_valid), .lsq_rob_id (lsq_rob_id), .lsq_is_store (lsq_is_store),
        .lsq_addr (lsq_addr), .lsq_mask (lsq_mask), .lsq_wdata (lsq_wdata),
        .lsq_misaligned (lsq_misaligned)
    );

endmodule

`default_nettype wire

// ==== bench/mem_issue_checks.svh ====
`ifndef MEM_ISSUE_CHECKS_SVH
`define MEM_ISSUE_CHECKS_SVH

////////////////////////////////////////////////////////////
// Expected LSQ results per rob_id
////////////////////////////////////////////////////////////

logic [mem_rs_pkg::XLEN-1:0]      exp_addr  [2**mem_rs_pkg::ROB_W];
logic [mem_rs_pkg::LANES-1:0]     exp_mask  [2**mem_rs_pkg::ROB_W];
logic [mem_rs_pkg::XLEN-1:0]      exp_wdata [2**mem_rs_pkg::ROB_W];
logic                             exp_store [2**mem_rs_pkg::ROB_W];
logic                             exp_mis   [2**mem_rs_pkg::ROB_W];
logic [2**mem_rs_pkg::ROB_W-1:0]  outstanding = '0;
logic [2**mem_rs_pkg::ROB_W-1:0]  blocked = '0;

// Register values as the CDB leaves them
logic [mem_rs_pkg::XLEN-1:0]      shadow [mem_rs_pkg::PRF_DEPTH] = '{default: '0};

// Top opcode bit marks a store, except the load parked on the last code
function automatic logic store_op(input logic [mem_rs_pkg::OP_W-1:0] op);
    return op[mem_rs_pkg::OP_W-1] && (op != mem_rs_pkg::OP_LHU);
endfunction

task automatic record_expected(input logic [mem_rs_pkg::ROB_W-1:0] rob,
                               input logic [mem_rs_pkg::OP_W-1:0] op,
                               input logic [mem_rs_pkg::XLEN-1:0] base,
                               input logic [mem_rs_pkg::XLEN-1:0] data,
                               input logic [mem_rs_pkg::IMM_W-1:0] imm);
    logic [mem_rs_pkg::XLEN-1:0]  addr;
    logic [1:0]                   off;
    logic [mem_rs_pkg::LANES-1:0] lanes;
    addr = base + {{(mem_rs_pkg::XLEN - mem_rs_pkg::IMM_W){imm[mem_rs_pkg::IMM_W-1]}}, imm};
    off  = addr[1:0];
    case (op)
        mem_rs_pkg::OP_LB, mem_rs_pkg::OP_LBU, mem_rs_pkg::OP_SB: lanes = 4'b0001;
        mem_rs_pkg::OP_LH, mem_rs_pkg::OP_LHU, mem_rs_pkg::OP_SH: lanes = 4'b0011;
        default:                                                  lanes = 4'b1111;
    endcase
    exp_addr[rob]    = addr;
    exp_mask[rob]    = lanes << off;
    exp_store[rob]   = store_op(op);
    exp_wdata[rob]   = store_op(op) ? (data << (8 * off)) : '0;
    exp_mis[rob]     = (lanes == 4'b0011) ? off[0] : ((lanes == 4'b1111) && (off != 2'd0));
    outstanding[rob] = 1'b1;
endtask

////////////////////////////////////////////////////////////
// Checks on the top-level ports
////////////////////////////////////////////////////////////

a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> ds_ready && !lsq_valid)
    else begin
        errors++;
        $display("ds_ready low or lsq_valid high as reset ended");
    end

a_known_rob: assert property (@(posedge clk) disable iff (!rst_n)
    lsq_valid |-> outstanding[lsq_rob_id])
    else begin
        errors++;
        $display("LSQ output for rob %0d that was not outstanding", $sampled(lsq_rob_id));
    end

a_not_early: assert property (@(posedge clk) disable iff (!rst_n)
    lsq_valid |-> !blocked[lsq_rob_id])
    else begin
        errors++;
        $display("rob %0d issued before its operand was broadcast", $sampled(lsq_rob_id));
    end

a_lsq_addr: assert property (@(posedge clk) disable iff (!rst_n)
    lsq_valid |-> lsq_addr == exp_addr[lsq_rob_id])
    else begin
        errors++;
        $display("mismatch lsq_addr rob %0d: got 0x%08h expected 0x%08h",
                 $sampled(lsq_rob_id), $sampled(lsq_addr), exp_addr[$sampled(lsq_rob_id)]);
    end

a_lsq_mask: assert property (@(posedge clk) disable iff (!rst_n)
    lsq_valid |-> lsq_mask == exp_mask[lsq_rob_id])
    else begin
        errors++;
        $display("mismatch lsq_mask rob %0d: got 0x%01h expected 0x%01h",
                 $sampled(lsq_rob_id), $sampled(lsq_mask), exp_mask[$sampled(lsq_rob_id)]);
    end

a_lsq_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    lsq_valid |-> lsq_wdata == exp_wdata[lsq_rob_id])
    else begin
        errors++;
        $display("mismatch lsq_wdata rob %0d: got 0x%08h expected 0x%08h",
                 $sampled(lsq_rob_id), $sampled(lsq_wdata), exp_wdata[$sampled(lsq_rob_id)]);
    end

a_lsq_is_store: assert property (@(posedge clk) disable iff (!rst_n)
    lsq_valid |-> lsq_is_store == exp_store[lsq_rob_id])
    else begin
        errors++;
        $display("mismatch lsq_is_store rob %0d: got 0x%01h expected 0x%01h",
                 $sampled(lsq_rob_id), $sampled(lsq_is_store),
                 exp_store[$sampled(lsq_rob_id)]);
    end

a_lsq_misaligned: assert property (@(posedge clk) disable iff (!rst_n)
    lsq_valid |-> lsq_misaligned == exp_mis[lsq_rob_id])
    else begin
        errors++;
        $display("mismatch lsq_misaligned rob %0d: got 0x%01h expected 0x%01h",
                 $sampled(lsq_rob_id), $sampled(lsq_misaligned),
                 exp_mis[$sampled(lsq_rob_id)]);
    end

// Lone dispatch with ready operands reaches the LSQ on the second edge
a_solo_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (solo && ds_valid && ds_ready) |->
        ##1 !lsq_valid ##1 (lsq_valid && lsq_rob_id == $past(ds_rob_id, 2)))
    else begin
        errors++;
        $display("lsq_valid did not follow a lone dispatch after 2 cycles");
    end

`endif

// ==== bench/mem_issue_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_issue_tb;

    localparam int OPS_TOTAL       = 1 + 4 + 4 + 9 + 40;
    localparam int WATCHDOG_CYCLES = OPS_TOTAL * 20;

    logic                              clk;
    logic                              rst_n;
    logic                              ds_valid;
    logic                              ds_ready;
    logic [mem_rs_pkg::ROB_W-1:0]      ds_rob_id;
    logic [mem_rs_pkg::OP_W-1:0]       ds_op;
    logic [mem_rs_pkg::PHY_W-1:0]      ds_rs1_phy;
    logic                              ds_rs1_ready;
    logic [mem_rs_pkg::PHY_W-1:0]      ds_rs2_phy;
    logic                              ds_rs2_ready;
    logic [mem_rs_pkg::IMM_W-1:0]      ds_imm;
    logic [mem_rs_pkg::CDB_WIDTH-1:0]  cdb_valid;
    logic [mem_rs_pkg::PHY_W-1:0]      cdb_tag   [mem_rs_pkg::CDB_WIDTH];
    logic [mem_rs_pkg::XLEN-1:0]       cdb_value [mem_rs_pkg::CDB_WIDTH];
    logic                              lsq_valid;
    logic [mem_rs_pkg::ROB_W-1:0]      lsq_rob_id;
    logic                              lsq_is_store;
    logic [mem_rs_pkg::XLEN-1:0]       lsq_addr;
    logic [mem_rs_pkg::LANES-1:0]      lsq_mask;
    logic [mem_rs_pkg::XLEN-1:0]       lsq_wdata;
    logic                              lsq_misaligned;

    int                           errors       = 0;
    int                           test_errors  = 0;
    int                           tests_passed = 0;
    int                           tests_failed = 0;
    logic [31:0]                  rng          = 32'd40;
    logic                         solo         = 1'b0;
    logic [mem_rs_pkg::ROB_W-1:0] rob_next     = '0;
    logic [mem_rs_pkg::ROB_W-1:0] last_rob;

    `include "mem_issue_checks.svh"

    mem_issue_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // Each LSQ output retires its rob_id
    always @(posedge clk) begin
        if (rst_n && lsq_valid) begin
            outstanding[lsq_rob_id] <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers entered and left 10 ns after an edge
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic set_value(input int tag);
        shadow[tag] = next_rand();
    endtask

    task automatic broadcast(input logic v0, input int t0, input logic v1, input int t1);
        cdb_valid    = {v1, v0};
        cdb_tag[0]   = t0[mem_rs_pkg::PHY_W-1:0];
        cdb_value[0] = shadow[t0];
        cdb_tag[1]   = t1[mem_rs_pkg::PHY_W-1:0];
        cdb_value[1] = shadow[t1];
        @(posedge clk);
        #10;
        cdb_valid = '0;
    endtask

    task automatic dispatch(input logic [mem_rs_pkg::OP_W-1:0] op, input int rs1,
                            input logic rs1_rdy, input int rs2, input logic rs2_rdy,
                            input logic [mem_rs_pkg::IMM_W-1:0] imm);
        logic [mem_rs_pkg::ROB_W-1:0] rob;
        rob      = rob_next;
        rob_next = rob_next + 1'b1;
        last_rob = rob;
        record_expected(rob, op, shadow[rs1], shadow[rs2], imm);
        blocked[rob] = !rs1_rdy || (store_op(op) && !rs2_rdy);
        ds_valid     = 1'b1;
        ds_rob_id    = rob;
        ds_op        = op;
        ds_rs1_phy   = rs1[mem_rs_pkg::PHY_W-1:0];
        ds_rs1_ready = rs1_rdy;
        ds_rs2_phy   = rs2[mem_rs_pkg::PHY_W-1:0];
        ds_rs2_ready = rs2_rdy;
        ds_imm       = imm;
        // Held while the station is full
        while (!ds_ready) begin
            @(posedge clk);
            #10;
        end
        @(posedge clk);
        #10;
        ds_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while (outstanding != '0 && n < limit) begin
            @(posedge clk);
            #10;
            n++;
        end
        a_all_retired: assert (outstanding == '0)
            else begin
                errors++;
                $display("rob ids never reached the LSQ, flags 0x%08h", outstanding);
                outstanding = '0;
                blocked     = '0;
            end
        idle(2);
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic reset_state();
        // Unwritten registers give an address equal to the immediate
        dispatch(mem_rs_pkg::OP_LW, 60, 1'b1, 61, 1'b1, 12'h804);
        drain(20);
    endtask

    task automatic solo_latency();
        for (int t = 1; t <= 4; t++) begin
            set_value(t);
        end
        broadcast(1'b1, 1, 1'b1, 2);
        broadcast(1'b1, 3, 1'b1, 4);
        solo = 1'b1;
        dispatch(mem_rs_pkg::OP_LW, 1, 1'b1, 2, 1'b1, 12'h010);
        drain(20);
        dispatch(mem_rs_pkg::OP_SW, 2, 1'b1, 3, 1'b1, 12'hff8);
        drain(20);
        dispatch(mem_rs_pkg::OP_LBU, 3, 1'b1, 4, 1'b1, 12'h003);
        drain(20);
        dispatch(mem_rs_pkg::OP_SH, 4, 1'b1, 1, 1'b1, 12'h7fe);
        drain(20);
        solo = 1'b0;
    endtask

    task automatic cdb_wakeup();
        logic [mem_rs_pkg::ROB_W-1:0] ra;
        logic [mem_rs_pkg::ROB_W-1:0] rb;
        logic [mem_rs_pkg::ROB_W-1:0] rd;
        set_value(5);
        broadcast(1'b1, 5, 1'b0, 0);
        set_value(30);
        set_value(31);
        set_value(32);
        set_value(34);
        dispatch(mem_rs_pkg::OP_LW, 30, 1'b0, 35, 1'b0, 12'h020);
        ra = last_rob;
        dispatch(mem_rs_pkg::OP_SW, 31, 1'b0, 32, 1'b0, 12'h104);
        rb = last_rob;
        // Load with an unready rs2 goes straight through
        dispatch(mem_rs_pkg::OP_LH, 5, 1'b1, 33, 1'b0, 12'h002);
        dispatch(mem_rs_pkg::OP_SB, 5, 1'b1, 34, 1'b0, 12'h001);
        rd = last_rob;
        idle(4);
        blocked[ra] = 1'b0;
        broadcast(1'b1, 30, 1'b1, 31);
        idle(3);
        blocked[rb] = 1'b0;
        blocked[rd] = 1'b0;
        broadcast(1'b1, 32, 1'b1, 34);
        drain(40);
    endtask

    task automatic station_full();
        logic [mem_rs_pkg::ROB_W-1:0] r [8];
        logic [mem_rs_pkg::OP_W-1:0]  loads [5];
        loads = '{mem_rs_pkg::OP_LB, mem_rs_pkg::OP_LH, mem_rs_pkg::OP_LW,
                  mem_rs_pkg::OP_LBU, mem_rs_pkg::OP_LHU};
        for (int i = 0; i < 8; i++) begin
            set_value(40 + i);
            dispatch(loads[i % 5], 40 + i, 1'b1 == 1'b0, 50, 1'b0, 12'h0c0);
            r[i] = last_rob;
        end
        a_full_not_ready: assert (!ds_ready)
            else begin
                errors++;
                $display("ds_ready stayed high with all eight slots in use");
            end
        fork
            dispatch(mem_rs_pkg::OP_SW, 5, 1'b1, 5, 1'b1, 12'h040);
            begin
                idle(3);
                a_still_full: assert (!ds_ready)
                    else begin
                        errors++;
                        $display("ds_ready rose while no slot had been freed");
                    end
                blocked[r[0]] = 1'b0;
                broadcast(1'b1, 40, 1'b0, 0);
            end
        join
        for (int i = 1; i < 8; i += 2) begin
            blocked[r[i]] = 1'b0;
            if (i + 1 < 8) begin
                blocked[r[i+1]] = 1'b0;
            end
            broadcast(1'b1, 40 + i, (i + 1 < 8), 40 + i + 1);
        end
        drain(60);
    endtask

    task automatic random_mix();
        logic [31:0] a;
        logic [31:0] b;
        for (int t = 1; t <= 16; t += 2) begin
            set_value(t);
            set_value(t + 1);
            broadcast(1'b1, t, 1'b1, t + 1);
        end
        for (int k = 0; k < 40; k++) begin
            a = next_rand();
            b = next_rand();
            dispatch(a[2:0], 1 + b[3:0], 1'b1, 1 + b[7:4], 1'b1, a[23:12]);
        end
        drain(200);
    endtask

    initial begin
        rst_n        = 1'b0;
        ds_valid     = 1'b0;
        ds_rob_id    = '0;
        ds_op        = '0;
        ds_rs1_phy   = '0;
        ds_rs1_ready = 1'b0;
        ds_rs2_phy   = '0;
        ds_rs2_ready = 1'b0;
        ds_imm       = '0;
        cdb_valid    = '0;
        cdb_tag      = '{default: '0};
        cdb_value    = '{default: '0};
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        idle(1);
        reset_state();
        end_test("reset_state");
        solo_latency();
        end_test("solo_latency");
        cdb_wakeup();
        end_test("cdb_wakeup");
        station_full();
        end_test("station_full");
        random_mix();
        end_test("random_mix");
        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+bench
src/mem_rs_pkg.sv
src/rs_slot.sv
src/mem_rs.sv
src/phys_reg_file.sv
src/agu_stage.sv
src/mem_issue_top.sv
bench/mem_issue_tb.sv

// ==== Bender.yml ====
package:
  name: mem_issue

sources:
  # RTL in compile order
  - files:
      - src/mem_rs_pkg.sv
      - src/rs_slot.sv
      - src/mem_rs.sv
      - src/phys_reg_file.sv
      - src/agu_stage.sv
      - src/mem_issue_top.sv

  # Testbench, top module mem_issue_tb
  - target: test
    include_dirs:
      - bench
    files:
      - bench/mem_issue_tb.sv

export_include_dirs:
  - bench
